//--- hdl/rv_isa_pkg.sv
// RV32I opcodes, funct3/funct7 codes, instruction field positions, word and index types
package rv_isa_pkg;

	// Data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Field positions inside the instruction word
	localparam int f_rd_lsb = 7;
	localparam int f_funct3_lsb = 12;
	localparam int f_rs1_lsb = 15;
	localparam int f_rs2_lsb = 20;
	localparam int f_funct7_lsb = 25;

	// ----------------------------------------
	// Major opcodes, bits 6:0
	localparam logic [6:0] op_rtype = 7'b0110011;
	localparam logic [6:0] op_itype = 7'b0010011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;

	// ----------------------------------------
	// ALU funct3, shared by R and I forms
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	// Memory and branch funct3
	localparam logic [2:0] f3_lw = 3'b010;
	localparam logic [2:0] f3_sw = 3'b010;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// funct7, only sub sets bit 30
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub = 7'b0100000;

endpackage

//--- hdl/rv_core_pkg.sv
// Core-internal enums for ALU operation, operand forwarding source and write-back source
package rv_core_pkg;

	// ----------------------------------------
	// ALU operation, chosen in decode
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or = 4'd3,
		alu_xor = 4'd4,
		// Shift amount from operand b bits 4:0
		alu_sll = 4'd5,
		alu_srl = 4'd6,
		// Signed compare, result 0 or 1
		alu_slt = 4'd7
	} alu_op_e;

	// ----------------------------------------
	// Operand source in execute
	typedef enum logic [1:0] {
		// Value read in decode
		fwd_reg = 2'd0,
		// Result sitting in the execute/memory register
		fwd_ex = 2'd1,
		// Value on the write-back bus
		fwd_wb = 2'd2
	} fwd_sel_e;

	// ----------------------------------------
	// Write-back source in memory stage
	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_mem = 2'd1,
		// Link value for jal
		wb_pc4 = 2'd2
	} wb_src_e;

endpackage

//--- hdl/fetch_stage.sv
// Fetch stage: PC, instruction memory with load port, next-PC mux, fetch/decode register
`timescale 1ns/1ns

module fetch_stage #(
	parameter int imem_words = 64
) (
	input logic clk_i,
	input logic rst_i,
	input logic imem_we_i,
	input logic [$clog2(imem_words)-1:0] imem_addr_i,
	input rv_isa_pkg::word_t imem_data_i,
	input logic redirect_i,
	input rv_isa_pkg::word_t target_i,
	output logic if_valid_o,
	output rv_isa_pkg::word_t if_instr_o,
	output rv_isa_pkg::word_t if_pc_o,
	output rv_isa_pkg::word_t if_pc_plus4_o
);
	import rv_isa_pkg::*;

	localparam int imem_aw = $clog2(imem_words);

	word_t imem [imem_words];
	word_t pc;
	word_t pc_plus4;
	word_t next_pc;
	logic [imem_aw-1:0] pc_word;

	// Word index into the program memory
	assign pc_word = pc[imem_aw+1:2];
	assign pc_plus4 = pc + word_t'(4);
	// Redirect from execute/memory register wins
	assign next_pc = redirect_i ? target_i : pc_plus4;

	// ----------------------------------------
	// Program load port
	always_ff @(posedge clk_i) begin
		if (imem_we_i) begin
			imem[imem_addr_i] <= imem_data_i;
		end
	end

	// PC held at zero during reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	// ----------------------------------------
	// Fetch/decode register
	always_ff @(posedge clk_i) begin
		// Bubble on reset or redirect
		if (rst_i || redirect_i) begin
			if_valid_o <= 1'b0;
		end else begin
			if_valid_o <= 1'b1;
		end
		if_instr_o <= imem[pc_word];
		if_pc_o <= pc;
		if_pc_plus4_o <= pc_plus4;
	end

	// Branch and jump targets from execute keep the PC on word boundaries
	pc_aligned_a: assert property (@(posedge clk_i) disable iff (rst_i)
		pc[1:0] == 2'b00);

endmodule

//--- hdl/decode_stage.sv
// Main control, ALU control, immediate generation and the decode/execute register
`timescale 1ns/1ns

module decode_stage (
	input logic clk_i,
	input logic rst_i,
	input logic squash_i,
	input logic if_valid_i,
	input rv_isa_pkg::word_t if_instr_i,
	input rv_isa_pkg::word_t if_pc_i,
	input rv_isa_pkg::word_t if_pc_plus4_i,
	input rv_isa_pkg::word_t rs1_data_i,
	input rv_isa_pkg::word_t rs2_data_i,
	output rv_isa_pkg::reg_idx_t rs1_idx_o,
	output rv_isa_pkg::reg_idx_t rs2_idx_o,
	output logic id_valid_o,
	output rv_core_pkg::alu_op_e id_alu_op_o,
	output logic id_alu_src_imm_o,
	output logic id_reg_we_o,
	output logic id_mem_we_o,
	output logic id_is_branch_o,
	output logic id_branch_ne_o,
	output logic id_is_jal_o,
	output rv_core_pkg::wb_src_e id_wb_src_o,
	output rv_isa_pkg::word_t id_imm_o,
	output rv_isa_pkg::reg_idx_t id_rs1_idx_o,
	output rv_isa_pkg::reg_idx_t id_rs2_idx_o,
	output rv_isa_pkg::reg_idx_t id_rd_o,
	output rv_isa_pkg::word_t id_rs1_data_o,
	output rv_isa_pkg::word_t id_rs2_data_o,
	output rv_isa_pkg::word_t id_pc_o,
	output rv_isa_pkg::word_t id_pc_plus4_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rd;
	word_t imm_i, imm_s, imm_b, imm_j, imm;
	alu_op_e alu_dec, alu_op;
	logic alu_ok, known, dec_valid;
	logic alu_src_imm, reg_we, mem_we, is_branch, branch_ne, is_jal;
	wb_src_e wb_src;

	assign opcode = if_instr_i[6:0];
	assign funct3 = if_instr_i[f_funct3_lsb +: 3];
	assign funct7 = if_instr_i[f_funct7_lsb +: 7];
	assign rd = if_instr_i[f_rd_lsb +: 5];
	// Register file read addresses
	assign rs1_idx_o = if_instr_i[f_rs1_lsb +: 5];
	assign rs2_idx_o = if_instr_i[f_rs2_lsb +: 5];

	// ----------------------------------------
	// Immediates sign-extended from bit 31
	assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
	assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
	assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
		if_instr_i[30:25], if_instr_i[11:8], 1'b0};
	assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
		if_instr_i[20], if_instr_i[30:21], 1'b0};

	// ALU control from funct3 with sub only in R form
	always_comb begin
		alu_ok = 1'b1;
		case (funct3)
			f3_add_sub: alu_dec = (opcode == op_rtype && funct7 == f7_sub) ?
				alu_sub : alu_add;
			f3_sll: alu_dec = alu_sll;
			f3_slt: alu_dec = alu_slt;
			f3_xor: alu_dec = alu_xor;
			f3_srl: alu_dec = alu_srl;
			f3_or: alu_dec = alu_or;
			f3_and: alu_dec = alu_and;
			default: begin
				// sltu not kept
				alu_dec = alu_add;
				alu_ok = 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	// Main control
	always_comb begin
		known = 1'b1;
		alu_op = alu_add;
		alu_src_imm = 1'b0;
		reg_we = 1'b0;
		mem_we = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jal = 1'b0;
		wb_src = wb_alu;
		imm = imm_i;
		case (opcode)
			op_rtype: begin
				// Rejects mul and sra encodings
				known = alu_ok && (funct7 == f7_base ||
					(funct3 == f3_add_sub && funct7 == f7_sub));
				alu_op = alu_dec;
				reg_we = 1'b1;
			end
			op_itype: begin
				// No immediate shifts
				known = alu_ok && funct3 != f3_sll && funct3 != f3_srl;
				alu_op = alu_dec;
				alu_src_imm = 1'b1;
				reg_we = 1'b1;
			end
			op_load: begin
				known = (funct3 == f3_lw);
				alu_src_imm = 1'b1;
				reg_we = 1'b1;
				wb_src = wb_mem;
			end
			op_store: begin
				known = (funct3 == f3_sw);
				alu_src_imm = 1'b1;
				mem_we = 1'b1;
				imm = imm_s;
			end
			op_branch: begin
				known = (funct3 == f3_beq || funct3 == f3_bne);
				is_branch = 1'b1;
				branch_ne = (funct3 == f3_bne);
				imm = imm_b;
			end
			op_jal: begin
				is_jal = 1'b1;
				reg_we = 1'b1;
				wb_src = wb_pc4;
				imm = imm_j;
			end
			default: known = 1'b0;
		endcase
	end

	// Unknown encodings become bubbles
	assign dec_valid = if_valid_i && known;

	// ----------------------------------------
	// Decode/execute register
	always_ff @(posedge clk_i) begin
		if (rst_i || squash_i) begin
			id_valid_o <= 1'b0;
			id_reg_we_o <= 1'b0;
			id_mem_we_o <= 1'b0;
			id_is_branch_o <= 1'b0;
			id_is_jal_o <= 1'b0;
		end else begin
			id_valid_o <= dec_valid;
			// x0 destination never writes
			id_reg_we_o <= dec_valid && reg_we && rd != '0;
			id_mem_we_o <= dec_valid && mem_we;
			id_is_branch_o <= dec_valid && is_branch;
			id_is_jal_o <= dec_valid && is_jal;
		end
		id_alu_op_o <= alu_op;
		id_alu_src_imm_o <= alu_src_imm;
		id_branch_ne_o <= branch_ne;
		id_wb_src_o <= wb_src;
		id_imm_o <= imm;
		id_rs1_idx_o <= rs1_idx_o;
		id_rs2_idx_o <= rs2_idx_o;
		id_rd_o <= rd;
		id_rs1_data_o <= rs1_data_i;
		id_rs2_data_o <= rs2_data_i;
		id_pc_o <= if_pc_i;
		id_pc_plus4_o <= if_pc_plus4_i;
	end

endmodule

//--- hdl/reg_file.sv
// Register file: 32 registers, x0 fixed at zero, write-through on both read ports
`timescale 1ns/1ns

module reg_file (
	input logic clk_i,
	input logic rst_i,
	input rv_isa_pkg::reg_idx_t rs1_idx_i,
	input rv_isa_pkg::reg_idx_t rs2_idx_i,
	output rv_isa_pkg::word_t rs1_data_o,
	output rv_isa_pkg::word_t rs2_data_o,
	input logic we_i,
	input rv_isa_pkg::reg_idx_t rd_i,
	input rv_isa_pkg::word_t wd_i
);
	import rv_isa_pkg::*;

	word_t regs [32];
	logic wr_en;

	// x0 never written so it reads zero
	assign wr_en = we_i && rd_i != '0;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[rd_i] <= wd_i;
		end
	end

	// ----------------------------------------
	// Same-cycle write returns new value
	assign rs1_data_o = (wr_en && rd_i == rs1_idx_i) ? wd_i : regs[rs1_idx_i];
	assign rs2_data_o = (wr_en && rd_i == rs2_idx_i) ? wd_i : regs[rs2_idx_i];

endmodule

//--- hdl/execute_stage.sv
// Forwarding select, ALU, branch test, target adder and the execute/memory register
`timescale 1ns/1ns

module execute_stage (
	input logic clk_i,
	input logic rst_i,
	input logic id_valid_i,
	input rv_core_pkg::alu_op_e id_alu_op_i,
	input logic id_alu_src_imm_i,
	input logic id_reg_we_i,
	input logic id_mem_we_i,
	input logic id_is_branch_i,
	input logic id_branch_ne_i,
	input logic id_is_jal_i,
	input rv_core_pkg::wb_src_e id_wb_src_i,
	input rv_isa_pkg::word_t id_imm_i,
	input rv_isa_pkg::reg_idx_t id_rs1_idx_i,
	input rv_isa_pkg::reg_idx_t id_rs2_idx_i,
	input rv_isa_pkg::reg_idx_t id_rd_i,
	input rv_isa_pkg::word_t id_rs1_data_i,
	input rv_isa_pkg::word_t id_rs2_data_i,
	input rv_isa_pkg::word_t id_pc_i,
	input rv_isa_pkg::word_t id_pc_plus4_i,
	input logic mem_wb_we_i,
	input rv_isa_pkg::reg_idx_t mem_wb_rd_i,
	input rv_isa_pkg::word_t mem_wb_data_i,
	output logic redirect_o,
	output rv_isa_pkg::word_t target_o,
	output logic ex_reg_we_o,
	output logic ex_mem_we_o,
	output rv_core_pkg::wb_src_e ex_wb_src_o,
	output rv_isa_pkg::reg_idx_t ex_rd_o,
	output rv_isa_pkg::word_t ex_result_o,
	output rv_isa_pkg::word_t ex_store_data_o,
	output rv_isa_pkg::word_t ex_pc_plus4_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	fwd_sel_e fwd_a, fwd_b;
	word_t op_a, op_b, alu_b, alu_y, target;
	logic taken, redirect_d;

	// Younger producer first; loads in execute/memory have no data yet
	function automatic fwd_sel_e fwd_pick(input reg_idx_t rs);
		if (ex_reg_we_o && ex_wb_src_o == wb_alu && ex_rd_o == rs) begin
			return fwd_ex;
		end
		if (mem_wb_we_i && mem_wb_rd_i == rs) begin
			return fwd_wb;
		end
		return fwd_reg;
	endfunction

	function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
		case (sel)
			fwd_ex: return ex_result_o;
			fwd_wb: return mem_wb_data_i;
			default: return reg_val;
		endcase
	endfunction

	// ----------------------------------------
	// Operand selection
	always_comb begin
		fwd_a = fwd_pick(id_rs1_idx_i);
		fwd_b = fwd_pick(id_rs2_idx_i);
		op_a = fwd_value(fwd_a, id_rs1_data_i);
		op_b = fwd_value(fwd_b, id_rs2_data_i);
	end
	assign alu_b = id_alu_src_imm_i ? id_imm_i : op_b;

	always_comb begin
		case (id_alu_op_i)
			alu_add: alu_y = op_a + alu_b;
			alu_sub: alu_y = op_a - alu_b;
			alu_and: alu_y = op_a & alu_b;
			alu_or: alu_y = op_a | alu_b;
			alu_xor: alu_y = op_a ^ alu_b;
			alu_sll: alu_y = op_a << alu_b[4:0];
			alu_srl: alu_y = op_a >> alu_b[4:0];
			alu_slt: alu_y = word_t'($signed(op_a) < $signed(alu_b));
			default: alu_y = '0;
		endcase
	end

	// Branch compares register operands rather than the immediate
	assign taken = id_is_branch_i && ((op_a == op_b) != id_branch_ne_i);
	assign redirect_d = id_valid_i && (taken || id_is_jal_i);
	assign target = id_pc_i + id_imm_i;

	// ----------------------------------------
	// Execute/memory register bubbled behind its own redirect
	always_ff @(posedge clk_i) begin
		if (rst_i || redirect_o) begin
			redirect_o <= 1'b0;
			ex_reg_we_o <= 1'b0;
			ex_mem_we_o <= 1'b0;
		end else begin
			redirect_o <= redirect_d;
			ex_reg_we_o <= id_valid_i && id_reg_we_i;
			ex_mem_we_o <= id_valid_i && id_mem_we_i;
		end
		target_o <= target;
		ex_wb_src_o <= id_wb_src_i;
		ex_rd_o <= id_rd_i;
		ex_result_o <= alu_y;
		ex_store_data_o <= op_b;
		ex_pc_plus4_o <= id_pc_plus4_i;
	end

endmodule

//--- hdl/memory_stage.sv
// Memory stage: data RAM, write-back source mux, memory/write-back register
`timescale 1ns/1ns

module memory_stage #(
	parameter int dmem_words = 256
) (
	input logic clk_i,
	input logic rst_i,
	input logic ex_reg_we_i,
	input logic ex_mem_we_i,
	input rv_core_pkg::wb_src_e ex_wb_src_i,
	input rv_isa_pkg::reg_idx_t ex_rd_i,
	input rv_isa_pkg::word_t ex_result_i,
	input rv_isa_pkg::word_t ex_store_data_i,
	input rv_isa_pkg::word_t ex_pc_plus4_i,
	output logic mem_wb_we_o,
	output rv_isa_pkg::reg_idx_t mem_wb_rd_o,
	output rv_isa_pkg::word_t mem_wb_data_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	localparam int dmem_aw = $clog2(dmem_words);

	word_t dmem [dmem_words];
	logic [dmem_aw-1:0] word_addr;
	word_t load_data, wb_data;

	// Word accesses only
	assign word_addr = ex_result_i[dmem_aw+1:2];
	// Asynchronous read
	assign load_data = dmem[word_addr];

	always_ff @(posedge clk_i) begin
		if (ex_mem_we_i) begin
			dmem[word_addr] <= ex_store_data_i;
		end
	end

	always_comb begin
		case (ex_wb_src_i)
			wb_mem: wb_data = load_data;
			wb_pc4: wb_data = ex_pc_plus4_i;
			default: wb_data = ex_result_i;
		endcase
	end

	// ----------------------------------------
	// Memory/write-back register
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mem_wb_we_o <= 1'b0;
		end else begin
			mem_wb_we_o <= ex_reg_we_i;
		end
		mem_wb_rd_o <= ex_rd_i;
		mem_wb_data_o <= wb_data;
	end

	store_in_range_a: assert property (@(posedge clk_i) disable iff (rst_i)
		ex_mem_we_i |-> (ex_result_i >> 2) < dmem_words);

endmodule

//--- hdl/rv_pipeline.sv
// Top level of the five-stage RV32I core: stage instances, register file, write-back port
`timescale 1ns/1ns

module rv_pipeline #(
	parameter int imem_words = 64,
	parameter int dmem_words = 256
) (
	input logic clk_i,
	input logic rst_i,
	input logic imem_we_i,
	input logic [$clog2(imem_words)-1:0] imem_addr_i,
	input rv_isa_pkg::word_t imem_data_i,
	output logic wb_valid_o,
	output rv_isa_pkg::reg_idx_t wb_rd_o,
	output rv_isa_pkg::word_t wb_data_o
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	// Fetch to decode
	logic if_valid;
	word_t if_instr, if_pc, if_pc_plus4;
	// Register file ports
	reg_idx_t rs1_idx, rs2_idx;
	word_t rs1_data, rs2_data;
	// Decode to execute
	logic id_valid, id_alu_src_imm, id_reg_we, id_mem_we;
	logic id_is_branch, id_branch_ne, id_is_jal;
	alu_op_e id_alu_op;
	wb_src_e id_wb_src;
	reg_idx_t id_rs1_idx, id_rs2_idx, id_rd;
	word_t id_imm, id_rs1_data, id_rs2_data, id_pc, id_pc_plus4;
	// Execute to memory, redirect back to the front
	logic redirect, ex_reg_we, ex_mem_we;
	wb_src_e ex_wb_src;
	reg_idx_t ex_rd;
	word_t target, ex_result, ex_store_data, ex_pc_plus4;
	// Write-back bus
	logic mem_wb_we;
	reg_idx_t mem_wb_rd;
	word_t mem_wb_data;

	fetch_stage #(.imem_words(imem_words)) fetch_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
		.redirect_i(redirect), .target_i(target),
		.if_valid_o(if_valid), .if_instr_o(if_instr),
		.if_pc_o(if_pc), .if_pc_plus4_o(if_pc_plus4)
	);

	decode_stage decode_i (
		.clk_i(clk_i), .rst_i(rst_i), .squash_i(redirect),
		.if_valid_i(if_valid), .if_instr_i(if_instr),
		.if_pc_i(if_pc), .if_pc_plus4_i(if_pc_plus4),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
		.id_valid_o(id_valid), .id_alu_op_o(id_alu_op), .id_alu_src_imm_o(id_alu_src_imm),
		.id_reg_we_o(id_reg_we), .id_mem_we_o(id_mem_we),
		.id_is_branch_o(id_is_branch), .id_branch_ne_o(id_branch_ne),
		.id_is_jal_o(id_is_jal), .id_wb_src_o(id_wb_src), .id_imm_o(id_imm),
		.id_rs1_idx_o(id_rs1_idx), .id_rs2_idx_o(id_rs2_idx), .id_rd_o(id_rd),
		.id_rs1_data_o(id_rs1_data), .id_rs2_data_o(id_rs2_data),
		.id_pc_o(id_pc), .id_pc_plus4_o(id_pc_plus4)
	);

	reg_file reg_file_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
		.we_i(mem_wb_we), .rd_i(mem_wb_rd), .wd_i(mem_wb_data)
	);

	execute_stage execute_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.id_valid_i(id_valid), .id_alu_op_i(id_alu_op), .id_alu_src_imm_i(id_alu_src_imm),
		.id_reg_we_i(id_reg_we), .id_mem_we_i(id_mem_we),
		.id_is_branch_i(id_is_branch), .id_branch_ne_i(id_branch_ne),
		.id_is_jal_i(id_is_jal), .id_wb_src_i(id_wb_src), .id_imm_i(id_imm),
		.id_rs1_idx_i(id_rs1_idx), .id_rs2_idx_i(id_rs2_idx), .id_rd_i(id_rd),
		.id_rs1_data_i(id_rs1_data), .id_rs2_data_i(id_rs2_data),
		.id_pc_i(id_pc), .id_pc_plus4_i(id_pc_plus4),
		.mem_wb_we_i(mem_wb_we), .mem_wb_rd_i(mem_wb_rd), .mem_wb_data_i(mem_wb_data),
		.redirect_o(redirect), .target_o(target),
		.ex_reg_we_o(ex_reg_we), .ex_mem_we_o(ex_mem_we), .ex_wb_src_o(ex_wb_src),
		.ex_rd_o(ex_rd), .ex_result_o(ex_result),
		.ex_store_data_o(ex_store_data), .ex_pc_plus4_o(ex_pc_plus4)
	);

	memory_stage #(.dmem_words(dmem_words)) memory_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.ex_reg_we_i(ex_reg_we), .ex_mem_we_i(ex_mem_we), .ex_wb_src_i(ex_wb_src),
		.ex_rd_i(ex_rd), .ex_result_i(ex_result),
		.ex_store_data_i(ex_store_data), .ex_pc_plus4_i(ex_pc_plus4),
		.mem_wb_we_o(mem_wb_we), .mem_wb_rd_o(mem_wb_rd), .mem_wb_data_o(mem_wb_data)
	);

	// Retiring writes seen from outside
	assign wb_valid_o = mem_wb_we;
	assign wb_rd_o = mem_wb_rd;
	assign wb_data_o = mem_wb_data;

endmodule

//--- tests/tb_rv_asm.svh
// Instruction encoders, program image with halt and fill, reset-time load, write-back wait
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

// ----------------------------------------
// Encoders, bit order as in the RV32I base formats
function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
	input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
	return {f7, rs2, rs1, f3, rd, op_rtype};
endfunction

// Also used for lw
function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
	input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t s_type(input reg_idx_t rs2, input reg_idx_t rs1,
	input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3_sw, imm[4:0], op_store};
endfunction

// Byte offset, bit 0 not encoded
function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
	input reg_idx_t rs2, input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic word_t j_type(input reg_idx_t rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

function automatic word_t addi(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
	return i_type(op_itype, f3_add_sub, rd, rs1, imm);
endfunction

// Program, then a jal-to-self halt, then nops tagged with their own address
function automatic word_t program_word(input int a);
	if (a < prog.size()) begin
		return prog[a];
	end
	if (a == prog.size()) begin
		return j_type(5'd0, 21'd0);
	end
	return addi(5'd0, 5'd0, 12'(a));
endfunction

// ----------------------------------------
// Load whole imem under reset, hold reset a few cycles more, then release
task automatic load_program();
	@(negedge clk);
	rst = 1'b1;
	for (int a = 0; a < imem_words + reset_cycles; a++) begin
		imem_we = (a < imem_words);
		imem_addr = imem_aw'(a);
		imem_data = program_word(a);
		@(negedge clk);
		check_value("wb_valid during reset", '0, word_t'(wb_valid));
	end
	imem_we = 1'b0;
	rst = 1'b0;
endtask

// Next retirement must match; sampled at the falling edge
task automatic wait_wb(input reg_idx_t rd, input word_t value);
	int n;
	logic seen;
	n = 0;
	seen = 1'b0;
	while (!seen && n < wb_timeout) begin
		@(negedge clk);
		n++;
		seen = wb_valid;
	end
	if (seen) begin
		check_value("wb_rd", word_t'(rd), word_t'(wb_rd));
		check_value("wb_data", value, wb_data);
	end else begin
		$display("%s: no write-back to x%0d within %0d cycles", cur_test, rd, wb_timeout);
		errors++;
	end
endtask

`endif

//--- tests/tb_rv_pipeline.sv
// Clock, reset, DUT, LFSR, check task and directed tests for the pipelined RV32I core
`timescale 1ns/1ns

module tb_rv_pipeline;
	import rv_isa_pkg::*;

	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	localparam int imem_aw = $clog2(imem_words);
	// Extra reset cycles after the program load
	localparam int reset_cycles = 8;
	localparam int wb_timeout = 40;
	localparam word_t lfsr_taps = 32'h80200003;

	logic clk = 1'b0;
	logic rst, imem_we;
	logic [imem_aw-1:0] imem_addr;
	word_t imem_data;
	logic wb_valid;
	reg_idx_t wb_rd;
	word_t wb_data;

	word_t lfsr;
	string cur_test;
	int errors, checks, tests, test_start;
	// Program and expected retirements of the current test
	word_t prog[$];
	reg_idx_t exp_rd[$];
	word_t exp_val[$];

	rv_pipeline #(.imem_words(imem_words), .dmem_words(dmem_words)) rv_pipeline_i (
		.clk_i(clk), .rst_i(rst), .imem_we_i(imem_we), .imem_addr_i(imem_addr),
		.imem_data_i(imem_data), .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
	);

	// 20 ns period
	always #10 clk = ~clk;

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			$display("Fail %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, expected,
				actual);
			errors++;
		end
	endtask

	`include "tb_rv_asm.svh"

	// ----------------------------------------
	// Galois LFSR stepped once per bit
	function automatic word_t rand_bits(input int n);
		word_t v;
		logic b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) begin
				lfsr = lfsr ^ lfsr_taps;
			end
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// ----------------------------------------
	// Test bookkeeping
	task automatic begin_test(input string name);
		cur_test = name;
		test_start = errors;
		tests++;
		prog.delete();
		exp_rd.delete();
		exp_val.delete();
	endtask

	task automatic end_test();
		if (errors == test_start) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errors - test_start);
		end
	endtask

	task automatic emit(input word_t instr);
		prog.push_back(instr);
	endtask

	// Instruction plus the write-back it must produce
	task automatic emit_wb(input word_t instr, input reg_idx_t rd, input word_t value);
		prog.push_back(instr);
		exp_rd.push_back(rd);
		exp_val.push_back(value);
	endtask

	// Halted core must stay silent
	task automatic expect_quiet(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(negedge clk);
			if (wb_valid) begin
				$display("%s: unexpected write-back to x%0d", cur_test, wb_rd);
				errors++;
			end
		end
	endtask

	task automatic run_program();
		load_program();
		for (int i = 0; i < exp_rd.size(); i++) begin
			wait_wb(exp_rd[i], exp_val[i]);
		end
		expect_quiet(12);
		end_test();
	endtask

	// ----------------------------------------
	// Directed tests
	task automatic test_reset();
		begin_test("reset");
		emit(addi(5'd1, 5'd0, 12'h02a));
		load_program();
		// Three empty cycles before the first retire on the fourth edge
		for (int c = 1; c <= 3; c++) begin
			@(negedge clk);
			check_value("wb_valid before first retire", '0, word_t'(wb_valid));
		end
		@(negedge clk);
		check_value("wb_valid on edge 4", 32'd1, word_t'(wb_valid));
		check_value("wb_rd on edge 4", 32'd1, word_t'(wb_rd));
		check_value("wb_data on edge 4", 32'h2a, wb_data);
		expect_quiet(12);
		end_test();
	endtask

	// Dependencies at distance 1, 2 and 3
	task automatic test_arith();
		word_t r, v1, v2, v3, v4, v5, v7, v8, v9, v10, v11, v12, v13, v14, v15;
		logic [11:0] i1, i2, i3, i4;
		logic [4:0] sh;
		begin_test("arith");
		r = rand_bits(12);
		i1 = r[11:0];
		r = rand_bits(12);
		i2 = r[11:0];
		r = rand_bits(12);
		i3 = r[11:0];
		r = rand_bits(12);
		i4 = r[11:0];
		r = rand_bits(5);
		sh = r[4:0];
		v1 = sext12(i1);
		v2 = sext12(i2);
		v3 = v1 + v2;
		v4 = v3 - v1;
		v5 = v4 ^ v1;
		v7 = v5 << sh;
		v8 = ($signed(v7) < $signed(v3)) ? 32'd1 : 32'd0;
		v9 = ($signed(v4) < $signed(sext12(i3))) ? 32'd1 : 32'd0;
		v10 = v7 >> sh;
		v11 = v10 & v2;
		v12 = v11 | v1;
		v13 = v12 & sext12(i4);
		v14 = v13 | sext12(i3);
		v15 = v14 ^ sext12(i4);
		emit_wb(addi(5'd1, 5'd0, i1), 5'd1, v1);
		emit_wb(addi(5'd2, 5'd0, i2), 5'd2, v2);
		emit_wb(r_type(f7_base, f3_add_sub, 5'd3, 5'd1, 5'd2), 5'd3, v3);
		emit_wb(r_type(f7_sub, f3_add_sub, 5'd4, 5'd3, 5'd1), 5'd4, v4);
		emit_wb(r_type(f7_base, f3_xor, 5'd5, 5'd4, 5'd1), 5'd5, v5);
		emit_wb(addi(5'd6, 5'd0, {7'd0, sh}), 5'd6, {27'd0, sh});
		emit_wb(r_type(f7_base, f3_sll, 5'd7, 5'd5, 5'd6), 5'd7, v7);
		emit_wb(r_type(f7_base, f3_slt, 5'd8, 5'd7, 5'd3), 5'd8, v8);
		emit_wb(i_type(op_itype, f3_slt, 5'd9, 5'd4, i3), 5'd9, v9);
		emit_wb(r_type(f7_base, f3_srl, 5'd10, 5'd7, 5'd6), 5'd10, v10);
		emit_wb(r_type(f7_base, f3_and, 5'd11, 5'd10, 5'd2), 5'd11, v11);
		emit_wb(r_type(f7_base, f3_or, 5'd12, 5'd11, 5'd1), 5'd12, v12);
		emit_wb(i_type(op_itype, f3_and, 5'd13, 5'd12, i4), 5'd13, v13);
		emit_wb(i_type(op_itype, f3_or, 5'd14, 5'd13, i3), 5'd14, v14);
		emit_wb(i_type(op_itype, f3_xor, 5'd15, 5'd14, i4), 5'd15, v15);
		run_program();
	endtask

	task automatic test_x0();
		begin_test("x0");
		emit_wb(addi(5'd1, 5'd0, 12'h155), 5'd1, 32'h155);
		// Would give 0x954 if x0 were writable
		emit(addi(5'd0, 5'd1, 12'h7ff));
		emit_wb(r_type(f7_base, f3_add_sub, 5'd2, 5'd0, 5'd1), 5'd2, 32'h155);
		emit_wb(r_type(f7_base, f3_add_sub, 5'd3, 5'd1, 5'd0), 5'd3, 32'h155);
		run_program();
	endtask

	task automatic test_store_load();
		word_t r, v;
		begin_test("store_load");
		r = rand_bits(12);
		v = sext12(r[11:0]);
		emit_wb(addi(5'd1, 5'd0, 12'd64), 5'd1, 32'd64);
		emit_wb(addi(5'd2, 5'd0, r[11:0]), 5'd2, v);
		emit_wb(r_type(f7_base, f3_add_sub, 5'd3, 5'd2, 5'd2), 5'd3, v + v);
		emit(s_type(5'd3, 5'd1, 12'd8));
		emit_wb(addi(5'd4, 5'd0, 12'd1), 5'd4, 32'd1);
		// Load two slots after the store and use two slots after the load
		emit_wb(i_type(op_load, f3_lw, 5'd5, 5'd1, 12'd8), 5'd5, v + v);
		emit_wb(addi(5'd6, 5'd0, 12'd3), 5'd6, 32'd3);
		emit_wb(r_type(f7_base, f3_add_sub, 5'd7, 5'd5, 5'd4), 5'd7, v + v + 32'd1);
		run_program();
	endtask

	task automatic test_branch();
		begin_test("branch");
		emit_wb(addi(5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
		emit_wb(addi(5'd2, 5'd0, 12'd5), 5'd2, 32'd5);
		emit(b_type(f3_beq, 5'd1, 5'd2, 13'd16));
		// Shadow of the taken beq
		emit(addi(5'd3, 5'd0, 12'd1));
		emit(addi(5'd4, 5'd0, 12'd2));
		emit(addi(5'd5, 5'd0, 12'd3));
		emit_wb(addi(5'd6, 5'd0, 12'd4), 5'd6, 32'd4);
		emit(b_type(f3_bne, 5'd1, 5'd2, 13'd16));
		emit_wb(addi(5'd7, 5'd0, 12'd7), 5'd7, 32'd7);
		emit_wb(addi(5'd8, 5'd0, 12'd8), 5'd8, 32'd8);
		emit_wb(addi(5'd9, 5'd0, 12'd9), 5'd9, 32'd9);
		run_program();
	endtask

	task automatic test_jal();
		word_t link;
		begin_test("jal");
		emit_wb(addi(5'd1, 5'd0, 12'd11), 5'd1, 32'd11);
		// Link is the byte address of the jal plus 4
		link = word_t'(prog.size()) * 32'd4 + 32'd4;
		emit_wb(j_type(5'd5, 21'd16), 5'd5, link);
		emit(addi(5'd2, 5'd0, 12'd1));
		emit(addi(5'd3, 5'd0, 12'd2));
		emit(addi(5'd4, 5'd0, 12'd3));
		emit_wb(addi(5'd6, 5'd5, 12'd1), 5'd6, link + 32'd1);
		emit_wb(addi(5'd7, 5'd1, 12'd2), 5'd7, 32'd13);
		run_program();
	endtask

	// ----------------------------------------
	initial begin
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		lfsr = 32'he1d31772;
		errors = 0;
		checks = 0;
		tests = 0;
		test_reset();
		test_arith();
		test_x0();
		test_store_load();
		test_branch();
		test_jal();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+tests
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_pipeline.sv
tests/tb_rv_pipeline.sv

//--- Makefile
# Verilator build and run for the pipelined RV32I core

VERILATOR ?= verilator
TOP ?= tb_rv_pipeline
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_TEXT ?= Simulation PASSED

SOURCES := $(FLIST) $(wildcard hdl/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the log, not from the simulator exit code
sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
